// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f src.f --top-module tb_boot_loader
	./obj_dir/Vtb_boot_loader | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== boot_cmds.hex ====
// Boot commands, 36 bits each: skip, enable, dm_select, reserved,
// src_start[31:16], count[15:0]
400000006
E00400005
600100004
000800003
400200000
400300005
601000007
000000000

// ==== design/block_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_counter (
  input  wire                   clock,
  input  wire                   ir_rst,
  input  wire                   load_count,
  input  wire boot_pkg::count_t count,
  input  wire                   step,
  output logic                  empty
);

  import boot_pkg::*;

  count_t remaining;  // Words still to be read

  always_ff @(posedge clock) begin
    if (ir_rst) begin
      remaining <= '0;
    end else if (load_count) begin
      remaining <= count;
    end else if (step) begin
      remaining <= remaining - count_t'(1);
    end
  end

  // Also true straight after a zero-count load
  assign empty = (remaining == '0);

endmodule

`default_nettype wire

// ==== design/boot_loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_loader_top (
  input  wire                      clock,
  input  wire                      ir_rst,
  input  wire                      start,
  output logic                     boot_done,
  output logic                     waiting,
  input  wire boot_pkg::tgt_addr_t im_rd_addr,
  input  wire boot_pkg::tgt_addr_t dm_rd_addr,
  output boot_pkg::word_t          im_rd_data,
  output boot_pkg::word_t          dm_rd_data
);

  import boot_pkg::*;

  rom_addr_t rom_addr;
  boot_cmd_t rom_data;
  logic      load;
  copy_req_t req;
  logic      load_count;
  count_t    count;
  logic      step;
  logic      empty;
  src_addr_t src_addr;
  word_t     src_data;
  tgt_wr_t   im_wr;
  tgt_wr_t   dm_wr;

  boot_sequencer u_seq (
    .clock, .ir_rst, .start,
    .rom_addr, .rom_data,
    .load, .req, .load_count, .count,
    .step, .empty,
    .waiting, .boot_done
  );

  block_counter u_cnt (.clock, .ir_rst, .load_count, .count, .step, .empty);

  copy_datapath u_dp (
    .clock, .ir_rst, .load, .req, .step,
    .src_addr, .src_data,
    .im_wr, .dm_wr
  );

  boot_rom   u_rom (.clock, .addr(rom_addr), .data(rom_data));
  source_mem u_src (.clock, .addr(src_addr), .data(src_data));

  // CPU-side read ports
  target_mem u_imem (.clock, .wr(im_wr), .rd_addr(im_rd_addr), .rd_data(im_rd_data));
  target_mem u_dmem (.clock, .wr(dm_wr), .rd_addr(dm_rd_addr), .rd_data(dm_rd_data));

endmodule

`default_nettype wire

// ==== design/boot_pkg.sv ====
`default_nettype none

package boot_pkg;

  localparam int ROM_DEPTH = 256;
  localparam int SRC_DEPTH = 1024;
  localparam int TGT_DEPTH = 1024;

  typedef logic [31:0] word_t;
  typedef logic [15:0] src_addr_t;  // Source memory decodes the low 10 bits
  typedef logic [9:0]  tgt_addr_t;
  typedef logic [7:0]  rom_addr_t;
  typedef logic [15:0] count_t;

  // Command word as held in the ROM, 36 bits
  typedef struct packed {
    logic      skip;
    logic      enable;     // Clear means pause here
    logic      dm_select;  // 0 IM, 1 DM
    logic      reserved;
    src_addr_t src_start;
    count_t    count;
  } boot_cmd_t;

  typedef struct packed {
    logic      dm_select;
    src_addr_t src_start;
  } copy_req_t;

  typedef struct packed {
    logic      wr;
    tgt_addr_t addr;
    word_t     data;
  } tgt_wr_t;

  typedef enum logic [2:0] {IDLE, FETCH, DECODE, LOAD, COPY, DRAIN, DONE} seq_state_t;

endpackage

`default_nettype wire

// ==== design/boot_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  wire                   clock,
  input  wire boot_pkg::rom_addr_t addr,
  output boot_pkg::boot_cmd_t   data
);

  import boot_pkg::*;

  boot_cmd_t rom [ROM_DEPTH];

  // Command list, terminated by an all-zero word
  initial begin
    $readmemh("boot_cmds.hex", rom);
  end

  always_ff @(posedge clock) begin
    data <= rom[addr];
  end

endmodule

`default_nettype wire

// ==== design/boot_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_sequencer (
  input  wire                      clock,
  input  wire                      ir_rst,
  input  wire                      start,
  output boot_pkg::rom_addr_t      rom_addr,
  input  wire boot_pkg::boot_cmd_t rom_data,
  output logic                     load,
  output boot_pkg::copy_req_t      req,
  output logic                     load_count,
  output boot_pkg::count_t         count,
  output logic                     step,
  input  wire                      empty,
  output logic                     waiting,
  output logic                     boot_done
);

  import boot_pkg::*;

  seq_state_t state;
  seq_state_t state_nxt;
  logic       pc_inc;
  logic       pause_hit;
  logic       paused;  // Set once a pause command has been seen

  always_comb begin
    state_nxt = state;
    pc_inc    = 1'b0;
    pause_hit = 1'b0;
    case (state)
      IDLE: begin
        if (start) begin
          state_nxt = FETCH;
        end
      end
      FETCH: state_nxt = DECODE;  // ROM read in flight
      DECODE: begin
        if (rom_data == '0) begin
          state_nxt = DONE;
        end else if (rom_data.skip) begin
          pc_inc    = 1'b1;
          state_nxt = FETCH;
        end else if (!rom_data.enable) begin
          // Resume with the next command on start
          pc_inc    = 1'b1;
          pause_hit = 1'b1;
          state_nxt = IDLE;
        end else begin
          state_nxt = LOAD;
        end
      end
      LOAD: begin
        pc_inc    = 1'b1;
        state_nxt = COPY;
      end
      COPY: begin
        if (empty) begin
          state_nxt = DRAIN;
        end
      end
      DRAIN:   state_nxt = FETCH;  // Last write lands
      DONE:    state_nxt = DONE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (ir_rst) begin
      state    <= IDLE;
      rom_addr <= '0;
      paused   <= 1'b0;
    end else begin
      state <= state_nxt;
      if (pc_inc) begin
        rom_addr <= rom_addr + rom_addr_t'(1);
      end
      if (pause_hit) begin
        paused <= 1'b1;
      end
    end
  end

  // ROM output still holds the decoded command during LOAD
  assign load          = (state == LOAD);
  assign load_count    = (state == LOAD);
  assign req.dm_select = rom_data.dm_select;
  assign req.src_start = rom_data.src_start;
  assign count         = rom_data.count;
  assign step          = (state == COPY) && !empty;
  assign waiting       = (state == IDLE) && paused;
  assign boot_done     = (state == DONE);

  // Running past the terminator would decode unloaded ROM words
  a_known_cmd: assert property (@(posedge clock) disable iff (ir_rst)
    (state == DECODE) |-> !$isunknown(rom_data))
    else $error("boot_sequencer: unknown command decoded");

endmodule

`default_nettype wire

// ==== design/copy_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module copy_datapath (
  input  wire                      clock,
  input  wire                      ir_rst,
  input  wire                      load,
  input  wire boot_pkg::copy_req_t req,
  input  wire                      step,
  output boot_pkg::src_addr_t      src_addr,
  input  wire boot_pkg::word_t     src_data,
  output boot_pkg::tgt_wr_t        im_wr,
  output boot_pkg::tgt_wr_t        dm_wr
);

  import boot_pkg::*;

  logic      dm_sel;      // Target of the current block
  logic      rd_pending;  // Source read issued last cycle
  tgt_addr_t im_ptr;
  tgt_addr_t dm_ptr;

  always_ff @(posedge clock) begin
    if (ir_rst) begin
      src_addr   <= '0;
      dm_sel     <= 1'b0;
      rd_pending <= 1'b0;
      im_ptr     <= '0;
      dm_ptr     <= '0;
    end else begin
      rd_pending <= step;
      if (load) begin
        src_addr <= req.src_start;
        dm_sel   <= req.dm_select;
      end else if (step) begin
        src_addr <= src_addr + src_addr_t'(1);
      end
      // Fill pointers carry on across blocks
      if (rd_pending && !dm_sel) begin
        im_ptr <= im_ptr + tgt_addr_t'(1);
      end
      if (rd_pending && dm_sel) begin
        dm_ptr <= dm_ptr + tgt_addr_t'(1);
      end
    end
  end

  always_comb begin
    im_wr.wr   = rd_pending && !dm_sel;
    im_wr.addr = im_ptr;
    im_wr.data = src_data;
    dm_wr.wr   = rd_pending && dm_sel;
    dm_wr.addr = dm_ptr;
    dm_wr.data = src_data;
  end

  // A new block must not reroute a word still in flight
  a_load_idle: assert property (@(posedge clock) disable iff (ir_rst)
    load |-> !rd_pending)
    else $error("copy_datapath: block loaded while a write is pending");

endmodule

`default_nettype wire

// ==== design/source_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module source_mem (
  input  wire                      clock,
  input  wire boot_pkg::src_addr_t addr,
  output boot_pkg::word_t          data
);

  import boot_pkg::*;

  word_t mem [SRC_DEPTH];

  initial begin
    $readmemh("src_data.hex", mem);
  end

  // Upper address bits are ignored
  always_ff @(posedge clock) begin
    data <= mem[addr[$clog2(SRC_DEPTH)-1:0]];
  end

endmodule

`default_nettype wire

// ==== design/target_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_mem (
  input  wire                      clock,
  input  wire boot_pkg::tgt_wr_t   wr,
  input  wire boot_pkg::tgt_addr_t rd_addr,
  output boot_pkg::word_t          rd_data
);

  import boot_pkg::*;

  word_t mem [TGT_DEPTH];

  // Power-up contents are zero
  initial begin
    for (int i = 0; i < TGT_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (wr.wr) begin
      mem[wr.addr] <= wr.data;
    end
    rd_data <= mem[rd_addr];  // One-cycle read
  end

endmodule

`default_nettype wire

// ==== sim/tb_boot_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_boot_loader;

  import boot_pkg::*;

  // Reset, idle checks, readback and the hold period
  localparam int OVERHEAD = 500;

  logic      clock;
  logic      ir_rst;
  logic      start;
  logic      boot_done;
  logic      waiting;
  tgt_addr_t im_rd_addr;
  tgt_addr_t dm_rd_addr;
  word_t     im_rd_data;
  word_t     dm_rd_data;

  logic [35:0] cmd_ref [ROM_DEPTH];
  word_t       src_ref [SRC_DEPTH];
  word_t       im_ref [TGT_DEPTH];
  word_t       dm_ref [TGT_DEPTH];
  int          im_fill;
  int          dm_fill;
  int          im_fill_at_pause;
  int          limit = 0;
  int          cycles;
  int          checks = 0;
  int          errors = 0;

  tb_clock_gen u_clk (.clock, .ir_rst);

  boot_loader_top u_dut (
    .clock, .ir_rst, .start, .boot_done, .waiting,
    .im_rd_addr, .dm_rd_addr, .im_rd_data, .dm_rd_data
  );

  // Expected target contents, walked from the command list
  function automatic void build_model();
    logic [35:0] c;
    logic [15:0] a;
    int          pc;
    int          n;
    for (int i = 0; i < TGT_DEPTH; i++) begin
      im_ref[tgt_addr_t'(i)] = '0;
      dm_ref[tgt_addr_t'(i)] = '0;
    end
    im_fill          = 0;
    dm_fill          = 0;
    im_fill_at_pause = -1;
    limit            = OVERHEAD + 4;  // Terminator fetch included
    pc               = 0;
    while (pc < ROM_DEPTH && cmd_ref[rom_addr_t'(pc)] != '0) begin
      c = cmd_ref[rom_addr_t'(pc)];
      n = int'(c[15:0]);
      limit += n + 4;
      if (!c[35] && !c[34]) begin
        if (im_fill_at_pause < 0) begin
          im_fill_at_pause = im_fill;
        end
      end else if (!c[35]) begin
        for (int k = 0; k < n; k++) begin
          a = c[31:16] + 16'(k);  // Source wraps on its low 10 bits
          if (c[33]) begin
            dm_ref[tgt_addr_t'(dm_fill)] = src_ref[a[9:0]];
            dm_fill++;
          end else begin
            im_ref[tgt_addr_t'(im_fill)] = src_ref[a[9:0]];
            im_fill++;
          end
        end
      end
      pc++;
    end
  endfunction

  task automatic check_level(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      $display("error: %s = %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  // One word through the CPU read port
  task automatic check_target(input bit use_dm, input int addr, input word_t exp);
    word_t got;
    @(posedge clock);
    if (use_dm) begin
      dm_rd_addr <= tgt_addr_t'(addr);
    end else begin
      im_rd_addr <= tgt_addr_t'(addr);
    end
    @(posedge clock);
    @(negedge clock);  // Read data settled
    got = use_dm ? dm_rd_data : im_rd_data;
    checks++;
    assert (got === exp) else begin
      $display("error: %s[%0h] = %08h, expected %08h",
               use_dm ? "dm_rd_data" : "im_rd_data", addr, got, exp);
      errors++;
    end
  endtask

  task automatic check_range(input bit use_dm, input int lo, input int hi);
    for (int i = lo; i < hi; i++) begin
      check_target(use_dm, i, use_dm ? dm_ref[tgt_addr_t'(i)] : im_ref[tgt_addr_t'(i)]);
    end
  endtask

  task automatic pulse_start();
    @(posedge clock);
    start <= 1'b1;
    @(posedge clock);
    start <= 1'b0;
  endtask

  task automatic wait_for_waiting();
    @(negedge clock);
    while (!waiting) begin
      @(negedge clock);
    end
  endtask

  task automatic wait_for_done();
    @(negedge clock);
    while (!boot_done) begin
      @(negedge clock);
    end
  endtask

  task automatic test_reset_idle();
    @(negedge clock);
    while (ir_rst) begin
      @(negedge clock);
    end
    repeat (10) begin
      check_level("boot_done", boot_done, 1'b0);
      check_level("waiting", waiting, 1'b0);
      @(negedge clock);
    end
  endtask

  task automatic test_run_to_pause();
    pulse_start();
    wait_for_waiting();
    check_level("boot_done", boot_done, 1'b0);
    check_range(1'b0, 0, im_fill_at_pause);
  endtask

  task automatic test_resume_to_done();
    pulse_start();
    wait_for_done();
    check_level("waiting", waiting, 1'b0);
    check_range(1'b0, 0, im_fill);  // Second IM block sits after the first
  endtask

  task automatic test_data_mem();
    check_range(1'b1, 0, dm_fill);
    check_range(1'b0, im_fill, im_fill + 8);  // Untouched words stay zero
    check_range(1'b1, dm_fill, dm_fill + 8);
  endtask

  task automatic test_hold_done();
    repeat (50) begin
      @(negedge clock);
      check_level("boot_done", boot_done, 1'b1);
    end
    pulse_start();
    repeat (4) @(negedge clock);
    check_level("boot_done", boot_done, 1'b1);
    check_range(1'b0, 0, im_fill + 8);
    check_range(1'b1, 0, dm_fill + 8);
  endtask

  initial begin
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: run stopped after %0d cycles", cycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    start      = 1'b0;
    im_rd_addr = '0;
    dm_rd_addr = '0;
    $readmemh("boot_cmds.hex", cmd_ref);
    $readmemh("src_data.hex", src_ref);
    build_model();
    test_reset_idle();
    test_run_to_pause();
    test_resume_to_done();
    test_data_mem();
    test_hold_done();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clock,
  output logic ir_rst
);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;  // 20 ns period
  end

  initial begin
    ir_rst = 1'b1;
    repeat (8) @(posedge clock);
    ir_rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== src.f ====
design/boot_pkg.sv
design/boot_rom.sv
design/source_mem.sv
design/target_mem.sv
design/block_counter.sv
design/copy_datapath.sv
design/boot_sequencer.sv
design/boot_loader_top.sv
sim/tb_clock_gen.sv
sim/tb_boot_loader.sv

// ==== src_data.hex ====
// Source memory contents, one 32-bit word per entry
// Lines starting with @ set the word address
@000
c0de0000 c0de0101 c0de0202 c0de0303
c0de0404 c0de0505 c0de0606 c0de0707
@010
da7a0010 da7a0011 da7a0012 da7a0013
@030
1a5e0030 1a5e0031 1a5e0032 1a5e0033 1a5e0034 1a5e0035
@040
5c1b0040 5c1b0041 5c1b0042 5c1b0043 5c1b0044
@080
9a0e0080 9a0e0081 9a0e0082
@100
d0a10100 d0a10101 d0a10102 d0a10103 d0a10104 d0a10105 d0a10106 d0a10107
